// ==== verilog.f ====
+incdir+hw
hw/gba_loader_pkg.sv
hw/download_decoder.sv
hw/bios_word_packer.sv
hw/cart_header_scan.sv
hw/rom_write_port.sv
hw/gba_cart_loader.sv
verification/loader_checker.sv
verification/tb_gba_cart_loader.sv

// ==== Bender.yml ====
package:
  name: gba_cart_loader

export_include_dirs:
  - hw

sources:
  - hw/gba_loader_pkg.sv
  - hw/download_decoder.sv
  - hw/bios_word_packer.sv
  - hw/cart_header_scan.sv
  - hw/rom_write_port.sv
  - hw/gba_cart_loader.sv
  - target: simulation
    files:
      - verification/loader_checker.sv
      - verification/tb_gba_cart_loader.sv

// ==== verification/tb_gba_cart_loader.sv ====
// Loader testbench
// Clock, reset, random host downloads and a ROM memory responder
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module tb_gba_cart_loader;

	logic                       clk_sys;
	logic                       reset;
	logic                       download;
	logic [7:0]                 index;
	logic                       rom_ack;
	logic                       ioctl_wait;
	gba_loader_pkg::dl_word_t   host_wr;
	gba_loader_pkg::bios_wr_t   bios_wr;
	gba_loader_pkg::rom_req_t   rom_req;
	gba_loader_pkg::cart_info_t cart_info;
	int                         errors;
	int                         timeouts;
	int                         c;
	logic [7:0]                 idx;
	logic [7:0]                 img [256];   // Image bytes of the next download

	gba_cart_loader DUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.download   (download),
		.index      (index),
		.host_wr    (host_wr),
		.rom_ack    (rom_ack),
		.bios_wr    (bios_wr),
		.rom_req    (rom_req),
		.ioctl_wait (ioctl_wait),
		.cart_info  (cart_info)
	);

	loader_checker u_checker (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.download   (download),
		.index      (index),
		.host_wr    (host_wr),
		.rom_ack    (rom_ack),
		.bios_wr    (bios_wr),
		.rom_req    (rom_req),
		.ioctl_wait (ioctl_wait),
		.cart_info  (cart_info),
		.errors     (errors)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Memory responder, ack 1 to 8 cycles after the request
	initial begin
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_req.req) begin
				repeat ($urandom_range(0, 7) + 1) @(posedge clk_sys);
				#1 rom_ack = 1'b1;
				@(posedge clk_sys);
				#1 rom_ack = 1'b0;
			end
		end
	end

	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_ready;
		int n;
		n = 0;
		while (ioctl_wait && (n < 50)) begin
			next_cycle();
			n++;
		end
		if (ioctl_wait) begin
			$display("Timeout at %0t ns: ioctl_wait stayed high for 50 cycles", $time);
			timeouts++;
		end
	endtask

	task automatic write_half(input logic [26:0] addr, input logic [15:0] data);
		wait_ready();                            // No writes under back-pressure
		host_wr = '{addr: addr, data: data, wr: 1'b1};
		next_cycle();
		host_wr.wr = 1'b0;
	endtask

	task automatic send_image(input logic [7:0] kind_idx, input logic [26:0] base, input int len);
		int a;
		download = 1'b1;
		index    = kind_idx;
		repeat (2) next_cycle();                 // Kind settles before the first write
		for (a = 0; a < len; a += 2)
			write_half(base + 27'(a), {img[a+1], img[a]});
		wait_ready();
		download = 1'b0;
		repeat (4) next_cycle();
	endtask

	task automatic fill_random(input int len);
		int i;
		for (i = 0; i < len; i++)
			img[i] = 8'($urandom);
	endtask

	// 0..3 quirk titles, 4 random title
	task automatic place_title(input int sel);
		logic [95:0] t;
		int          i;
		case (sel)
			0:       t = "ROCKY BOXING";
			1:       t = "DBZ TAIKETSU";
			2:       t = {"SUPER MARIO", 8'h00};
			3:       t = {"ZELDA 1", 40'h0};
			default: t = {$urandom, $urandom, $urandom};
		endcase
		for (i = 0; i < `GBA_TITLE_LEN; i++)
			img[`GBA_TITLE_BASE + i] = t[95 - 8*i -: 8];
	endtask

	// 0 no signature, 1 ends on the low lane, 2 ends on the high lane
	task automatic place_flash(input int lane);
		logic [71:0] sig;
		int          s;
		int          i;
		sig = "FLASH1M_V";
		s   = 16 + 2 * $urandom_range(0, 40) + ((lane == 2) ? 1 : 0);
		if (lane != 0)
			for (i = 0; i < 9; i++)
				img[s + i] = sig[71 - 8*i -: 8];
	endtask

	initial begin
		void'($urandom(32'hcf1e3f23));
		reset    = 1'b1;
		download = 1'b0;
		index    = 8'h00;
		host_wr  = '0;
		timeouts = 0;
		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b0;
		repeat (4) next_cycle();
		// BIOS download at a random word-aligned base
		fill_random(64);
		send_image(8'h00, 27'($urandom & 32'h3f00), 64);
		for (c = 0; c < 10; c++) begin
			fill_random(256);
			place_flash(c % 3);
			place_title(c % 5);
			idx       = 8'($urandom);
			idx[7:6]  = 2'(c);                   // Walk all cart types
			if (idx == 8'h00)
				idx = 8'h01;
			if (idx == 8'hff)
				idx = 8'hfe;
			send_image(idx, 27'd0, 'hc0 + 2 * $urandom_range(0, 31));
			if (c == 5) begin
				fill_random(64);                 // Code download between carts
				send_image(8'hff, 27'd0, 64);
			end
		end
		repeat (4) next_cycle();
		$display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/loader_checker.sv ====
// Loader reference model and comparisons
// Watches the DUT ports, checks BIOS writes, ROM requests, wait level and cart info
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module loader_checker (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       download,
	input  logic [7:0]                 index,
	input  gba_loader_pkg::dl_word_t   host_wr,
	input  logic                       rom_ack,
	input  gba_loader_pkg::bios_wr_t   bios_wr,
	input  gba_loader_pkg::rom_req_t   rom_req,
	input  logic                       ioctl_wait,
	input  gba_loader_pkg::cart_info_t cart_info,
	output int                         errors
);

	gba_loader_pkg::dl_kind_e   kind;        // Kind the DUT works with this cycle
	gba_loader_pkg::bios_wr_t   bios_exp;    // Due one cycle after the odd halfword
	gba_loader_pkg::cart_info_t info_exp;
	logic [15:0]                low_half;
	logic                       wait_exp;
	logic                       cart_wr;
	logic                       in_cart;
	logic [71:0]                byte_hist;   // Cart bytes in stream order, newest at the bottom
	logic [95:0]                title;       // First title byte on top
	logic [24:0]                last_word;
	int                         low_cnt;     // Cycles since download fell
	int                         off;

	initial errors = 0;

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic gba_loader_pkg::dl_kind_e classify(input logic dl, input logic [7:0] idx);
		if (!dl)
			return gba_loader_pkg::DL_NONE;
		if (idx == 8'h00)
			return gba_loader_pkg::DL_BIOS;
		if (idx == 8'hff)
			return gba_loader_pkg::DL_CODE;    // Cheat codes
		return gba_loader_pkg::DL_CART;
	endfunction

	// One byte into the history, signature test after each one
	task automatic push_byte(input logic [7:0] b);
		byte_hist = {byte_hist[63:0], b};
		if (byte_hist == "FLASH1M_V")
			info_exp.flash_1m = 1'b1;
	endtask

	// Mid-cycle sampling, inputs and outputs both settled
	always @(negedge clk_sys) begin
		if (reset) begin
			kind     = gba_loader_pkg::DL_NONE;
			bios_exp = '0;
			info_exp = '0;
			wait_exp = 1'b0;
			in_cart  = 1'b0;
			low_cnt  = 2;
		end else begin
			cart_wr = (kind == gba_loader_pkg::DL_CART) && host_wr.wr;
			// ========================================
			// Compare
			// ========================================
			if (bios_wr.wr !== bios_exp.wr)
				report_mismatch($sformatf("bios_wr strobe %b, expected %b", bios_wr.wr, bios_exp.wr));
			else if (bios_exp.wr && (bios_wr !== bios_exp))
				report_mismatch($sformatf("bios_wr %h, expected %h", bios_wr, bios_exp));
			if (rom_req.req !== cart_wr)
				report_mismatch($sformatf("rom_req strobe %b, expected %b", rom_req.req, cart_wr));
			else if (cart_wr && ((rom_req.addr !== 26'((host_wr.addr >> 1) + `GBA_ROM_START_HW))
					|| (rom_req.data !== host_wr.data)))
				report_mismatch($sformatf("rom_req %h for host write %h", rom_req, host_wr));
			if (ioctl_wait !== wait_exp)
				report_mismatch($sformatf("ioctl_wait %b, expected %b", ioctl_wait, wait_exp));
			if ((low_cnt >= 2) && (cart_info !== info_exp))
				report_mismatch($sformatf("cart_info %h, expected %h", cart_info, info_exp));
			// ========================================
			// Model update
			// ========================================
			bios_exp.wr = 1'b0;
			if ((kind == gba_loader_pkg::DL_BIOS) && host_wr.wr) begin
				if (host_wr.addr[1])
					bios_exp = '{addr: host_wr.addr[13:2], data: {host_wr.data, low_half}, wr: 1'b1};
				else
					low_half = host_wr.data;
			end
			if (rom_ack || (kind != gba_loader_pkg::DL_CART))
				wait_exp = 1'b0;                   // Low from the cycle after the ack
			else if (cart_wr)
				wait_exp = 1'b1;
			if ((kind == gba_loader_pkg::DL_CART) && !in_cart) begin
				in_cart                     = 1'b1;   // New cart, flags start over
				byte_hist                   = '0;
				info_exp.cart_type          = index[7:6];
				info_exp.force_turbo        = (index[7:6] != 2'd0);
				info_exp.flash_1m           = 1'b0;
				info_exp.sram_quirk         = 1'b0;
				info_exp.memory_remap_quirk = 1'b0;
			end
			if (cart_wr) begin
				push_byte(host_wr.data[7:0]);          // Even address first
				push_byte(host_wr.data[15:8]);
				off = int'(host_wr.addr) - `GBA_TITLE_BASE;
				if ((off >= 0) && (off < `GBA_TITLE_LEN))
					title[95 - 8*off -: 16] = {host_wr.data[7:0], host_wr.data[15:8]};
				last_word = host_wr.addr[26:2];
			end
			low_cnt = download ? 0 : low_cnt + 1;
			if ((low_cnt == 2) && in_cart) begin
				in_cart                     = 1'b0;
				info_exp.last_addr          = last_word;
				info_exp.memory_remap_quirk = (title == {"SUPER MARIO", 8'h00}) ||
					(title == {"ZELDA 1", 40'h0});
				info_exp.sram_quirk         = info_exp.memory_remap_quirk ||
					(title == "ROCKY BOXING") || (title == "DBZ TAIKETSU");
			end
			kind = classify(download, index);      // Registered by the DUT at the next edge
		end
	end

endmodule

`default_nettype wire

// ==== hw/gba_cart_loader.sv ====
// Cartridge and BIOS loader top
// Decoder, BIOS packer, header scanner and ROM port
// Cart info bundle for the core
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module gba_cart_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        download,
	input  logic [7:0]                  index,
	input  gba_loader_pkg::dl_word_t    host_wr,
	input  logic                        rom_ack,
	output gba_loader_pkg::bios_wr_t    bios_wr,
	output gba_loader_pkg::rom_req_t    rom_req,
	output logic                        ioctl_wait,
	output gba_loader_pkg::cart_info_t  cart_info
);

	gba_loader_pkg::dl_kind_e  dl_kind;
	logic                      cart_start;
	logic [1:0]                cart_type;
	logic                      force_turbo;
	logic [`GBA_DL_ADDR_W-3:0] last_addr;
	logic                      flash_1m;
	logic                      sram_quirk;
	logic                      memory_remap_quirk;

	// ========================================
	// Blocks
	// ========================================
	download_decoder u_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.index       (index),
		.host_wr     (host_wr),
		.dl_kind     (dl_kind),
		.cart_start  (cart_start),
		.cart_end    (),
		.cart_type   (cart_type),
		.force_turbo (force_turbo),
		.last_addr   (last_addr)
	);

	bios_word_packer u_bios (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_kind (dl_kind),
		.host_wr (host_wr),
		.bios_wr (bios_wr)
	);

	cart_header_scan u_scan (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl_kind            (dl_kind),
		.cart_start         (cart_start),
		.host_wr            (host_wr),
		.flash_1m           (flash_1m),
		.sram_quirk         (sram_quirk),
		.memory_remap_quirk (memory_remap_quirk)
	);

	rom_write_port u_rom (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_kind    (dl_kind),
		.host_wr    (host_wr),
		.rom_ack    (rom_ack),
		.rom_req    (rom_req),
		.ioctl_wait (ioctl_wait)
	);

	// Settled once the end pulse has captured last_addr
	assign cart_info = '{
		cart_type:          cart_type,
		force_turbo:        force_turbo,
		flash_1m:           flash_1m,
		sram_quirk:         sram_quirk,
		memory_remap_quirk: memory_remap_quirk,
		last_addr:          last_addr
	};

endmodule

`default_nettype wire

// ==== hw/rom_write_port.sv ====
// Cartridge ROM write port
// Relocates cart words into the ROM region of external memory
// Host wait level, one request in flight
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module rom_write_port (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::dl_kind_e  dl_kind,
	input  gba_loader_pkg::dl_word_t  host_wr,
	input  logic                      rom_ack,
	output gba_loader_pkg::rom_req_t  rom_req,
	output logic                      ioctl_wait
);

	// Start of cart ROM, past WRAM and save areas
	localparam logic [`GBA_ROM_ADDR_W-1:0] rom_start_hw = `GBA_ROM_START_HW;

	logic                       cart_wr;
	logic [`GBA_ROM_ADDR_W-1:0] rom_addr;

	assign cart_wr  = (dl_kind == gba_loader_pkg::DL_CART) && host_wr.wr;
	assign rom_addr = host_wr.addr[`GBA_DL_ADDR_W-1:1] + rom_start_hw;   // Byte to halfword

	// Request goes out in the write cycle itself
	assign rom_req = '{addr: rom_addr, data: host_wr.data, req: cart_wr};

	// Wait level, holds the host off until memory has taken the word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
		end else if (dl_kind != gba_loader_pkg::DL_CART) begin
			ioctl_wait <= 1'b0;     // Never stall BIOS or code transfers
		end else if (rom_ack) begin
			ioctl_wait <= 1'b0;
		end else if (cart_wr) begin
			ioctl_wait <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cart_header_scan.sv ====
// Cartridge stream scanner
// Flash 1M signature search over a byte history
// Header title capture and the save-RAM and remap quirk table
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module cart_header_scan (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::dl_kind_e  dl_kind,
	input  logic                      cart_start,
	input  gba_loader_pkg::dl_word_t  host_wr,
	output logic                      flash_1m,
	output logic                      sram_quirk,
	output logic                      memory_remap_quirk
);

	// ========================================
	// Constants
	// ========================================
	localparam int sig_w  = `GBA_FLASH_SIG_LEN * 8;
	localparam int hist_w = sig_w - 8;            // All but the newest byte
	localparam int title_w = `GBA_TITLE_LEN * 8;

	localparam logic [sig_w-1:0] flash_sig = "FLASH1M_V";

	localparam logic [`GBA_DL_ADDR_W-1:0] title_base = `GBA_TITLE_BASE;
	localparam logic [`GBA_DL_ADDR_W-1:0] title_end  = `GBA_TITLE_BASE + `GBA_TITLE_LEN;
	localparam logic [3:0] title_last = `GBA_TITLE_LEN - 2;   // Offset of final halfword

	// Quirk titles, first character in the top byte
	localparam logic [title_w-1:0] title_rocky = "ROCKY BOXING";
	localparam logic [title_w-1:0] title_dbz   = "DBZ TAIKETSU";
	localparam logic [title_w-1:0] title_mario = {"SUPER MARIO", 8'h00};
	localparam logic [title_w-1:0] title_zelda = {"ZELDA 1", 40'h00_0000_0000};

	logic                      cart_wr;
	logic [7:0]                lo_byte;        // Byte at the even address
	logic [7:0]                hi_byte;
	logic [hist_w-1:0]         sig_hist;       // Recent bytes, oldest at the top
	logic                      sig_lo_hit;
	logic                      sig_hi_hit;
	logic [title_w-1:0]        cart_id;        // Title bytes gathered so far
	logic [`GBA_DL_ADDR_W-1:0] title_off;
	logic [3:0]                title_sel;      // Byte slot of this halfword, from the bottom
	logic                      in_title;
	logic [title_w-1:0]        title_now;      // Full title incl. the current halfword
	logic                      match_sram;
	logic                      match_remap;

	assign cart_wr = (dl_kind == gba_loader_pkg::DL_CART) && host_wr.wr;
	assign lo_byte = host_wr.data[7:0];
	assign hi_byte = host_wr.data[15:8];

	// ========================================
	// Flash signature
	// ========================================
	// Signature may end on either byte lane
	assign sig_lo_hit = ({sig_hist, lo_byte} == flash_sig);
	assign sig_hi_hit = ({sig_hist[hist_w-9:0], lo_byte, hi_byte} == flash_sig);

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			sig_hist <= {sig_hist[hist_w-17:0], lo_byte, hi_byte};
	end

	// ========================================
	// Header title
	// ========================================
	assign title_off = host_wr.addr - title_base;
	assign in_title  = (host_wr.addr >= title_base) && (host_wr.addr < title_end);
	assign title_sel = title_last - title_off[3:0];

	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title)
			cart_id[{title_sel, 3'd0} +: 16] <= {lo_byte, hi_byte};
	end

	// Last halfword still on the bus, so join it in directly
	assign title_now = {cart_id[title_w-1:16], lo_byte, hi_byte};

	always_comb begin
		match_sram  = 1'b0;
		match_remap = 1'b0;
		if ((title_now == title_rocky) || (title_now == title_dbz))
			match_sram = 1'b1;
		if ((title_now == title_mario) || (title_now == title_zelda)) begin
			match_sram  = 1'b1;    // Classic NES series carts
			match_remap = 1'b1;
		end
	end

	// Flags clear at the start of each cart, sticky afterwards
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m           <= 1'b0;
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
		end else begin
			if (cart_start) begin
				flash_1m           <= 1'b0;
				sram_quirk         <= 1'b0;
				memory_remap_quirk <= 1'b0;
			end
			if (cart_wr) begin
				if (sig_lo_hit || sig_hi_hit) flash_1m <= 1'b1;
				if (in_title && (title_off[3:0] == title_last)) begin
					if (match_sram)  sram_quirk         <= 1'b1;
					if (match_remap) memory_remap_quirk <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/bios_word_packer.sv ====
// BIOS halfword packer
// Joins halfword pairs of a BIOS download into 32-bit BIOS memory writes
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module bios_word_packer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::dl_kind_e  dl_kind,
	input  gba_loader_pkg::dl_word_t  host_wr,
	output gba_loader_pkg::bios_wr_t  bios_wr
);

	logic [15:0]                 low_half;     // Held until the odd halfword arrives
	logic [`GBA_BIOS_ADDR_W-1:0] word_addr;
	logic [31:0]                 word_data;
	logic                        word_wr;
	logic                        bios_hw_wr;

	assign bios_hw_wr = (dl_kind == gba_loader_pkg::DL_BIOS) && host_wr.wr;

	// Payload, loaded on each halfword
	always_ff @(posedge clk_sys) begin
		if (bios_hw_wr) begin
			if (!host_wr.addr[1]) begin
				low_half <= host_wr.data;               // Bits 15..0 of the word
			end else begin
				word_data <= {host_wr.data, low_half};  // Odd halfword completes it
				word_addr <= host_wr.addr[`GBA_BIOS_ADDR_W+1:2];
			end
		end
	end

	// One strobe per completed pair
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word_wr <= 1'b0;
		end else begin
			word_wr <= bios_hw_wr && host_wr.addr[1];
		end
	end

	assign bios_wr = '{addr: word_addr, data: word_data, wr: word_wr};

endmodule

`default_nettype wire

// ==== hw/download_decoder.sv ====
// Download classifier
// Registered download kind, cartridge start and end pulses
// Cartridge type, turbo flag and last written word address
`timescale 1ns/1ps
`default_nettype none

`include "gba_loader_macros.svh"

module download_decoder (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           download,
	input  logic [7:0]                     index,
	input  gba_loader_pkg::dl_word_t       host_wr,
	output gba_loader_pkg::dl_kind_e       dl_kind,
	output logic                           cart_start,
	output logic                           cart_end,
	output logic [1:0]                     cart_type,
	output logic                           force_turbo,
	output logic [`GBA_DL_ADDR_W-3:0]      last_addr
);

	gba_loader_pkg::dl_kind_e kind_next;
	gba_loader_pkg::dl_kind_e kind_prev;          // Kind one cycle back
	logic [`GBA_DL_ADDR_W-3:0] last_wr_addr;      // Word address of latest cart write

	// Classify from the index while download is high
	always_comb begin
		if (!download) begin
			kind_next = gba_loader_pkg::DL_NONE;
		end else if (index == 8'h00) begin
			kind_next = gba_loader_pkg::DL_BIOS;
		end else if (&index) begin
			kind_next = gba_loader_pkg::DL_CODE;  // Cheat codes, not a cart
		end else begin
			kind_next = gba_loader_pkg::DL_CART;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind   <= gba_loader_pkg::DL_NONE;
			kind_prev <= gba_loader_pkg::DL_NONE;
		end else begin
			dl_kind   <= kind_next;
			kind_prev <= dl_kind;
		end
	end

	// Edges of the cartridge phase
	assign cart_start = (dl_kind == gba_loader_pkg::DL_CART) &&
		(kind_prev != gba_loader_pkg::DL_CART);
	assign cart_end   = (kind_prev == gba_loader_pkg::DL_CART) &&
		(dl_kind != gba_loader_pkg::DL_CART);

	// Track the address of every cart write, the data bus moves on after the end
	always_ff @(posedge clk_sys) begin
		if ((dl_kind == gba_loader_pkg::DL_CART) && host_wr.wr)
			last_wr_addr <= host_wr.addr[`GBA_DL_ADDR_W-1:2];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 2'd0;
			last_addr <= '0;
		end else begin
			if (cart_start) cart_type <= index[7:6];   // Type bits from the file index
			if (cart_end)   last_addr <= last_wr_addr; // Max pak address for the core
		end
	end

	// Special cart types run the CPU at full turbo
	assign force_turbo = |cart_type;

endmodule

`default_nettype wire

// ==== hw/gba_loader_pkg.sv ====
// Loader types
// Download kind enum, host write, BIOS write, ROM request and cart info structs
`default_nettype none

`include "gba_loader_macros.svh"

package gba_loader_pkg;

	// Transfer class, decoded from the file index
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,   // Index 0
		DL_CART = 2'd2,   // Any other index
		DL_CODE = 2'd3    // Index all ones
	} dl_kind_e;

	// One host write, 16-bit data at a byte address
	typedef struct packed {
		logic [`GBA_DL_ADDR_W-1:0] addr;
		logic [15:0]               data;
		logic                      wr;
	} dl_word_t;

	typedef struct packed {
		logic [`GBA_BIOS_ADDR_W-1:0] addr;  // Word address
		logic [31:0]                 data;
		logic                        wr;
	} bios_wr_t;

	typedef struct packed {
		logic [`GBA_ROM_ADDR_W-1:0] addr;   // Halfword address
		logic [15:0]                data;
		logic                       req;
	} rom_req_t;

	// Cartridge properties seen by the core
	typedef struct packed {
		logic [1:0]                cart_type;
		logic                      force_turbo;
		logic                      flash_1m;
		logic                      sram_quirk;
		logic                      memory_remap_quirk;
		logic [`GBA_DL_ADDR_W-3:0] last_addr;   // Word address
	} cart_info_t;

endpackage

`default_nettype wire

// ==== hw/gba_loader_macros.svh ====
// Loader widths and address map
// Download, ROM and BIOS address widths, ROM start offset
// Header title location and flash signature length
`ifndef GBA_LOADER_MACROS_SVH
`define GBA_LOADER_MACROS_SVH

// ========================================
// Address widths
// ========================================
`define GBA_DL_ADDR_W      27      // Host byte address
`define GBA_ROM_ADDR_W     26      // ROM memory halfword address
`define GBA_BIOS_ADDR_W    12      // BIOS memory word address

// ROM region start, halfword address (byte offset 786432)
`define GBA_ROM_START_HW   393216

// ========================================
// Cartridge header layout
// ========================================
`define GBA_TITLE_BASE     'hA0    // First title byte
`define GBA_TITLE_LEN      12      // Title bytes, zero padded

// "FLASH1M_V" marks a 1 Mbit flash save chip
`define GBA_FLASH_SIG_LEN  9

`endif
